/* common/motion_cmd_pkg.sv */
// Bus word layout, command codes and version fields shared by the word decoder and move buffer
package motion_cmd_pkg;

  // Word layout
  localparam int word_bits = 64;
  localparam int header_msb = 63; // Command byte
  localparam int header_lsb = 56;
  localparam int channel_lsb = 48; // Motor channel for per-axis commands

  // Command codes
  localparam logic [7:0] cmd_coordinated_step = 8'h01;
  localparam logic [7:0] cmd_motor_enable = 8'h0a;
  localparam logic [7:0] cmd_motor_brake = 8'h0b;
  localparam logic [7:0] cmd_motor_config = 8'h10;
  localparam logic [7:0] cmd_clk_divisor = 8'h20;
  localparam logic [7:0] cmd_api_version = 8'hfe;

  // API version, replied in bytes 2, 1, 0 and 3
  localparam logic [7:0] version_major = 8'd1;
  localparam logic [7:0] version_minor = 8'd2;
  localparam logic [7:0] version_patch = 8'd0;
  localparam logic [7:0] version_devel = 8'd0;

  // Move field selection from decoder to move buffer
  localparam int field_bits = 2;
  localparam logic [field_bits-1:0] field_duration = 2'd0;
  localparam logic [field_bits-1:0] field_increment = 2'd1;
  localparam logic [field_bits-1:0] field_increment_step = 2'd2;

endpackage

/* common/motion_cfg_pkg.sv */
// Axis count, datapath widths, move buffer depth and reset defaults of the motion core
package motion_cfg_pkg;

  // Axes and widths
  localparam int num_motors = 2;
  localparam int axis_index_bits = 1; // Enough to select one of num_motors
  localparam int dda_bits = 64;
  localparam int move_duration_bits = 32;

  // Move buffer
  localparam int buffer_size = 2;
  localparam int buffer_index_bits = 1;

  // DDA clock divider
  localparam int divisor_bits = 8;

  // One bit per axis
  typedef logic [num_motors-1:0] motor_mask_t;

  // Per-axis byte setting
  typedef logic [7:0] setting_byte_t;

  // Reset values
  localparam logic [divisor_bits-1:0] default_clock_divisor = 8'd32;
  localparam setting_byte_t default_microsteps = 8'd64;
  localparam setting_byte_t default_current = 8'd140;

endpackage

/* logic/command_fsm.sv */
// Bus word decoder that holds motor settings and feeds move parameters to the move buffer
`timescale 1ns/1ns

module command_fsm (
  input  logic CLK,
  input  logic resetn,
  input  logic word_received,
  input  logic [motion_cmd_pkg::word_bits-1:0] word_data,
  output logic [motion_cmd_pkg::word_bits-1:0] word_send_data,
  output motion_cfg_pkg::motor_mask_t enable,
  output motion_cfg_pkg::motor_mask_t brake,
  output motion_cfg_pkg::setting_byte_t [motion_cfg_pkg::num_motors-1:0] microsteps,
  output motion_cfg_pkg::setting_byte_t [motion_cfg_pkg::num_motors-1:0] current,
  output logic [motion_cfg_pkg::divisor_bits-1:0] clock_divisor,
  output logic write_en,
  output logic [motion_cmd_pkg::field_bits-1:0] write_field,
  output logic [motion_cfg_pkg::axis_index_bits-1:0] write_axis,
  output logic [motion_cfg_pkg::dda_bits-1:0] write_value,
  output logic [motion_cfg_pkg::buffer_index_bits-1:0] write_slot,
  output logic commit,
  output motion_cfg_pkg::motor_mask_t dir_bits
);

  import motion_cmd_pkg::*;
  import motion_cfg_pkg::*;

  // Header word plus duration plus two words per axis
  localparam logic [7:0] last_word = 8'(2 * num_motors + 1);

  logic recv_d1;
  logic recv_d2;
  logic word_rise;
  logic [7:0] header;
  logic [7:0] word_count;
  logic [7:0] axis_count;
  logic [7:0] cmd_byte;
  logic [axis_index_bits-1:0] channel;
  logic awaiting_more;

  assign word_rise = recv_d1 & ~recv_d2;
  assign cmd_byte = word_data[header_msb:header_lsb];
  assign channel = word_data[channel_lsb +: axis_index_bits];
  assign axis_count = (word_count - 8'd2) >> 1; // Words 2,3 are axis 0, 4,5 axis 1

  // Version read takes the following word as a dummy
  assign awaiting_more = (header == cmd_coordinated_step) || (header == cmd_api_version);

  always_ff @(posedge CLK) begin
    if (resetn) begin
      recv_d1 <= 1'b0;
      recv_d2 <= 1'b0;
      word_send_data <= '0;
      enable <= '0;
      brake <= '0;
      clock_divisor <= default_clock_divisor;
      for (int a = 0; a < num_motors; a++) begin
        microsteps[a] <= default_microsteps;
        current[a] <= default_current;
      end
      header <= '0;
      word_count <= '0;
      write_en <= 1'b0;
      write_slot <= '0;
      commit <= 1'b0;
      dir_bits <= '0;
    end else begin
      recv_d1 <= word_received;
      recv_d2 <= recv_d1;
      write_en <= 1'b0;
      commit <= 1'b0;
      if (commit)
        write_slot <= write_slot + 1'b1; // Next slot once the buffer has seen the commit

      if (word_rise) begin
        word_send_data <= '0;

        if (!awaiting_more) begin
          header <= cmd_byte;
          word_count <= 8'd1;
          case (cmd_byte)
            cmd_coordinated_step: dir_bits <= word_data[num_motors-1:0];
            cmd_motor_enable: enable <= word_data[num_motors-1:0];
            cmd_motor_brake: brake <= word_data[num_motors-1:0];
            cmd_clk_divisor: clock_divisor <= word_data[divisor_bits-1:0];
            cmd_motor_config: begin
              current[channel] <= word_data[15:8];
              microsteps[channel][2:0] <= word_data[2:0]; // Upper bits keep their value
            end
            cmd_api_version: begin
              word_send_data[31:0] <= {version_devel, version_major,
                                       version_minor, version_patch};
            end
            default: word_send_data <= '0;
          endcase
        end else if (header == cmd_coordinated_step) begin
          word_count <= word_count + 8'd1;
          write_en <= 1'b1;
          write_value <= word_data[dda_bits-1:0];
          write_axis <= axis_count[axis_index_bits-1:0];
          if (word_count == 8'd1)
            write_field <= field_duration;
          else if (word_count[0])
            write_field <= field_increment_step; // Odd words
          else
            write_field <= field_increment;

          // Last axis done
          if (word_count == last_word) begin
            commit <= 1'b1;
            header <= '0;
            word_count <= '0;
          end
        end else begin
          header <= '0; // Dummy word after a version read
          word_count <= '0;
        end
      end
    end
  end

endmodule

/* logic/clock_divider.sv */
// Down-counter that paces the DDA with a one-cycle tick every divisor+1 clocks
`timescale 1ns/1ns

module clock_divider (
  input  logic CLK,
  input  logic resetn,
  input  logic [motion_cfg_pkg::divisor_bits-1:0] divisor,
  output logic tick
);

  import motion_cfg_pkg::*;

  logic [divisor_bits-1:0] count;

  always_ff @(posedge CLK) begin
    if (resetn) begin
      count <= '0;
      tick <= 1'b0;
    end else if (count == '0) begin
      count <= divisor; // Picks up a new divisor on each reload
      tick <= 1'b1;
    end else begin
      count <= count - 1'b1;
      tick <= 1'b0;
    end
  end

endmodule

/* move_buffer/move_buffer.sv */
// Two-slot move store written by the word decoder and read by the DDA sequencer
`timescale 1ns/1ns

module move_buffer (
  input  logic CLK,
  input  logic resetn,
  input  logic write_en,
  input  logic [motion_cmd_pkg::field_bits-1:0] write_field,
  input  logic [motion_cfg_pkg::axis_index_bits-1:0] write_axis,
  input  logic [motion_cfg_pkg::dda_bits-1:0] write_value,
  input  logic [motion_cfg_pkg::buffer_index_bits-1:0] write_slot,
  input  motion_cfg_pkg::motor_mask_t dir_bits,
  input  logic commit,
  input  logic [motion_cfg_pkg::buffer_index_bits-1:0] read_slot,
  output logic [motion_cfg_pkg::buffer_size-1:0] slot_ready_toggles,
  output logic [motion_cfg_pkg::move_duration_bits-1:0] move_duration,
  output logic [motion_cfg_pkg::num_motors-1:0][motion_cfg_pkg::dda_bits-1:0] increments,
  output logic [motion_cfg_pkg::num_motors-1:0][motion_cfg_pkg::dda_bits-1:0] increment_steps,
  output motion_cfg_pkg::motor_mask_t dir
);

  import motion_cmd_pkg::*;
  import motion_cfg_pkg::*;

  logic [move_duration_bits-1:0] duration_mem [buffer_size];
  logic [num_motors-1:0][dda_bits-1:0] increment_mem [buffer_size];
  logic [num_motors-1:0][dda_bits-1:0] step_mem [buffer_size];
  motor_mask_t dir_mem [buffer_size];

  always_ff @(posedge CLK) begin
    if (resetn) begin
      slot_ready_toggles <= '0;
      for (int s = 0; s < buffer_size; s++) begin
        duration_mem[s] <= '0;
        increment_mem[s] <= '0;
        step_mem[s] <= '0;
        dir_mem[s] <= '0;
      end
    end else begin
      if (write_en) begin
        case (write_field)
          field_duration: duration_mem[write_slot] <= write_value[move_duration_bits-1:0];
          field_increment: increment_mem[write_slot][write_axis] <= write_value;
          field_increment_step: step_mem[write_slot][write_axis] <= write_value;
          default: ;
        endcase
      end
      // Dir bits arrive with the header, stored when the move completes
      if (commit) begin
        dir_mem[write_slot] <= dir_bits;
        slot_ready_toggles[write_slot] <= ~slot_ready_toggles[write_slot];
      end
    end
  end

  assign move_duration = duration_mem[read_slot];
  assign increments = increment_mem[read_slot];
  assign increment_steps = step_mem[read_slot];
  assign dir = dir_mem[read_slot];

endmodule

/* dda/dda_fsm.sv */
// Sequencer that picks full buffer slots, times each move in DDA ticks and retires it
`timescale 1ns/1ns

module dda_fsm (
  input  logic CLK,
  input  logic resetn,
  input  logic dda_tick,
  input  logic [motion_cfg_pkg::buffer_size-1:0] slot_ready_toggles,
  input  logic [motion_cfg_pkg::move_duration_bits-1:0] move_duration,
  output logic [motion_cfg_pkg::buffer_index_bits-1:0] read_slot,
  output logic loading_move,
  output logic executing_move,
  output logic move_done,
  output logic buffer_dtr,
  input  logic [motion_cfg_pkg::buffer_index_bits-1:0] write_slot
);

  import motion_cfg_pkg::*;

  typedef enum logic [1:0] {
    state_idle,
    state_loading,
    state_executing
  } dda_state_t;

  dda_state_t state;
  logic [move_duration_bits-1:0] tick_count;
  logic [move_duration_bits-1:0] tick_next;
  logic [buffer_size-1:0] consumed;
  logic [buffer_size-1:0] slot_full;

  assign slot_full = slot_ready_toggles ^ consumed; // Full until both toggles agree
  assign tick_next = tick_count + 1'b1;
  assign loading_move = (state == state_loading);
  assign executing_move = (state == state_executing);
  assign buffer_dtr = ~slot_full[write_slot];

  always_ff @(posedge CLK) begin
    if (resetn) begin
      state <= state_idle;
      tick_count <= '0;
      consumed <= '0;
      read_slot <= '0;
      move_done <= 1'b0;
    end else begin
      move_done <= 1'b0;
      case (state)
        state_idle: begin
          if (slot_full[read_slot])
            state <= state_loading;
        end
        state_loading: begin
          tick_count <= '0;
          state <= state_executing;
        end
        state_executing: begin
          if (dda_tick) begin
            tick_count <= tick_next;
            // Zero duration also ends on its first tick
            if (tick_next >= move_duration) begin
              move_done <= 1'b1;
              consumed[read_slot] <= ~consumed[read_slot];
              read_slot <= read_slot + 1'b1;
              state <= state_idle;
            end
          end
        end
        default: state <= state_idle;
      endcase
    end
  end

endmodule

/* dda/dda_timer.sv */
// Per-axis DDA with linear velocity ramp that emits step pulses on accumulator wrap
`timescale 1ns/1ns

module dda_timer (
  input  logic CLK,
  input  logic resetn,
  input  logic dda_tick,
  input  logic [motion_cfg_pkg::dda_bits-1:0] increment,
  input  logic [motion_cfg_pkg::dda_bits-1:0] increment_step,
  input  logic loading_move,
  input  logic executing_move,
  output logic step
);

  import motion_cfg_pkg::*;

  logic [dda_bits-1:0] accumulator;
  logic [dda_bits-1:0] velocity;
  logic [dda_bits-1:0] acc_next;

  assign acc_next = accumulator + velocity; // Two's complement, works for both directions

  always_ff @(posedge CLK) begin
    if (resetn) begin
      accumulator <= '0;
      velocity <= '0;
      step <= 1'b0;
    end else begin
      step <= 1'b0;
      if (loading_move) begin
        accumulator <= '0;
        velocity <= increment; // Start speed
      end else if (executing_move && dda_tick) begin
        accumulator <= acc_next;
        velocity <= velocity + increment_step; // Acceleration
        // Top bit flip is one step
        step <= acc_next[dda_bits-1] ^ accumulator[dda_bits-1];
      end
    end
  end

endmodule

/* logic/stepper_core_top.sv */
// Top level of the stepper command and motion core, driven by words from the serial front end
`timescale 1ns/1ns

module stepper_core_top (
  input  logic CLK,
  input  logic resetn,
  input  logic word_received,
  input  logic [motion_cmd_pkg::word_bits-1:0] word_data,
  output logic [motion_cmd_pkg::word_bits-1:0] word_send_data,
  output logic buffer_dtr,
  output logic move_done,
  output motion_cfg_pkg::motor_mask_t step,
  output motion_cfg_pkg::motor_mask_t dir,
  output motion_cfg_pkg::motor_mask_t enable,
  output motion_cfg_pkg::motor_mask_t brake,
  output motion_cfg_pkg::setting_byte_t [motion_cfg_pkg::num_motors-1:0] microsteps,
  output motion_cfg_pkg::setting_byte_t [motion_cfg_pkg::num_motors-1:0] current
);

  import motion_cmd_pkg::*;
  import motion_cfg_pkg::*;

  // Decoder to buffer
  logic write_en;
  logic [field_bits-1:0] write_field;
  logic [axis_index_bits-1:0] write_axis;
  logic [dda_bits-1:0] write_value;
  logic [buffer_index_bits-1:0] write_slot;
  logic commit;
  motor_mask_t dir_bits;

  // Buffer to DDA
  logic [buffer_index_bits-1:0] read_slot;
  logic [buffer_size-1:0] slot_ready_toggles;
  logic [move_duration_bits-1:0] move_duration;
  logic [num_motors-1:0][dda_bits-1:0] increments;
  logic [num_motors-1:0][dda_bits-1:0] increment_steps;

  logic [divisor_bits-1:0] clock_divisor;
  logic dda_tick;
  logic loading_move;
  logic executing_move;

  command_fsm cmd_i (
    .CLK(CLK),
    .resetn(resetn),
    .word_received(word_received),
    .word_data(word_data),
    .word_send_data(word_send_data),
    .enable(enable),
    .brake(brake),
    .microsteps(microsteps),
    .current(current),
    .clock_divisor(clock_divisor),
    .write_en(write_en),
    .write_field(write_field),
    .write_axis(write_axis),
    .write_value(write_value),
    .write_slot(write_slot),
    .commit(commit),
    .dir_bits(dir_bits)
  );

  clock_divider div_i (
    .CLK(CLK),
    .resetn(resetn),
    .divisor(clock_divisor),
    .tick(dda_tick)
  );

  move_buffer buf_i (
    .CLK(CLK),
    .resetn(resetn),
    .write_en(write_en),
    .write_field(write_field),
    .write_axis(write_axis),
    .write_value(write_value),
    .write_slot(write_slot),
    .dir_bits(dir_bits),
    .commit(commit),
    .read_slot(read_slot),
    .slot_ready_toggles(slot_ready_toggles),
    .move_duration(move_duration),
    .increments(increments),
    .increment_steps(increment_steps),
    .dir(dir)
  );

  dda_fsm seq_i (
    .CLK(CLK),
    .resetn(resetn),
    .dda_tick(dda_tick),
    .slot_ready_toggles(slot_ready_toggles),
    .move_duration(move_duration),
    .read_slot(read_slot),
    .loading_move(loading_move),
    .executing_move(executing_move),
    .move_done(move_done),
    .buffer_dtr(buffer_dtr),
    .write_slot(write_slot)
  );

  // One DDA per axis, all sharing the move timing
  for (genvar i = 0; i < num_motors; i++) begin : g_axis
    dda_timer timer_i (
      .CLK(CLK),
      .resetn(resetn),
      .dda_tick(dda_tick),
      .increment(increments[i]),
      .increment_step(increment_steps[i]),
      .loading_move(loading_move),
      .executing_move(executing_move),
      .step(step[i])
    );
  end

endmodule

/* test/tb_stepper_core.sv */
// Testbench for the stepper core top level that replays the stim file words and checks replies
`timescale 1ns/1ns

module tb_stepper_core;

  import motion_cmd_pkg::*;
  import motion_cfg_pkg::*;

  localparam int max_lines = 64;

  logic CLK;
  logic resetn;
  logic word_received;
  logic [word_bits-1:0] word_data;
  logic [word_bits-1:0] word_send_data;
  logic buffer_dtr;
  logic move_done;
  motor_mask_t step;
  motor_mask_t dir;
  motor_mask_t enable;
  motor_mask_t brake;
  setting_byte_t [num_motors-1:0] microsteps;
  setting_byte_t [num_motors-1:0] current;

  // Parsed stimulus lines
  int test_ids [max_lines];
  logic [7:0] actions [max_lines];
  logic [word_bits-1:0] words [max_lines];
  logic [word_bits-1:0] expects [max_lines];
  int num_lines;

  int cycle = 0;
  int cycle_limit;
  int errors;
  int test_errors;
  int tests_run;
  int step_count [num_motors];
  logic [63:0] done_counts_q [$]; // Step counts per finished move, 32 bits per axis
  int done_cycle_q [$];
  int start_cycle_q [$];

  stepper_core_top dut_i (
    .CLK(CLK),
    .resetn(resetn),
    .word_received(word_received),
    .word_data(word_data),
    .word_send_data(word_send_data),
    .buffer_dtr(buffer_dtr),
    .move_done(move_done),
    .step(step),
    .dir(dir),
    .enable(enable),
    .brake(brake),
    .microsteps(microsteps),
    .current(current)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // Cycle counter and watchdog
  always @(posedge CLK) begin
    cycle <= cycle + 1;
    if (cycle >= cycle_limit) begin
      $display("Error: timeout after %0d cycles, a move or handshake never completed", cycle);
      $display("Result: FAILED");
      $finish;
    end
  end

  // Step pulses per axis, closed out on each move_done
  always @(negedge CLK) begin : count_steps
    logic [63:0] packed_counts;
    packed_counts = '0;
    if (!resetn) begin
      for (int a = 0; a < num_motors; a++)
        step_count[a] = step_count[a] + int'(step[a]);
      if (move_done) begin
        for (int a = 0; a < num_motors; a++) begin
          packed_counts[32*a +: 32] = step_count[a];
          step_count[a] = 0;
        end
        done_counts_q.push_back(packed_counts);
        done_cycle_q.push_back(cycle);
      end
    end
  end

  task automatic report_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    errors++;
    test_errors++;
    $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
  endtask

  task automatic finish_test(input int id);
    $display("Test %0d finished with %0d errors", id, test_errors);
    tests_run++;
    test_errors = 0;
  endtask

  // Strobe high for 2 cycles, low for 2
  task automatic send_word(input logic [word_bits-1:0] w);
    @(posedge CLK);
    word_data <= w;
    word_received <= 1'b1;
    repeat (2) @(posedge CLK);
    word_received <= 1'b0;
    repeat (2) @(posedge CLK);
  endtask

  task automatic read_stim();
    int fd;
    int fields;
    int id;
    logic [7:0] act;
    logic [word_bits-1:0] w;
    logic [word_bits-1:0] e;
    string line;
    num_lines = 0;
    fd = $fopen("test/stepper_stim.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd) && num_lines < max_lines) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#") begin // Skip comments and blank lines
          fields = $sscanf(line, "%d %h %h %h", id, act, w, e);
          if (fields == 4) begin
            test_ids[num_lines] = id;
            actions[num_lines] = act;
            words[num_lines] = w;
            expects[num_lines] = e;
            num_lines++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    int current_test;
    int start_cyc;
    int done_cyc;
    motor_mask_t mask;
    logic [63:0] counts;
    resetn = 1'b1;
    word_received = 1'b0;
    word_data = '0;
    errors = 0;
    test_errors = 0;
    tests_run = 0;
    void'($urandom(67381));
    read_stim();

    // Move durations times divisor+1, plus 200 cycles for each word sent
    cycle_limit = 10;
    for (int i = 0; i < num_lines; i++) begin
      if (actions[i] == 8'h9)
        cycle_limit += int'(words[i]);
      else if (actions[i] inside {8'h1, 8'h2, 8'h5, 8'h6, 8'he})
        cycle_limit += 200;
    end

    if (num_lines == 0) begin
      $display("Error: no stimulus lines could be read from test/stepper_stim.txt");
      errors = 1;
    end else begin
      repeat (3) @(posedge CLK);
      resetn <= 1'b0;
      current_test = test_ids[0];
      for (int i = 0; i < num_lines; i++) begin
        if (test_ids[i] != current_test) begin
          finish_test(current_test);
          current_test = test_ids[i];
        end
        case (actions[i])
          8'h0: begin
            @(negedge CLK);
            if (buffer_dtr !== 1'b1) report_value("buffer_dtr", 64'(buffer_dtr), 64'h1);
            if (enable !== '0) report_value("enable", 64'(enable), 64'h0);
            if (brake !== '0) report_value("brake", 64'(brake), 64'h0);
            if (step !== '0) report_value("step", 64'(step), 64'h0);
            if (move_done !== 1'b0) report_value("move_done", 64'(move_done), 64'h0);
            if (word_send_data !== '0) report_value("word_send_data", word_send_data, 64'h0);
            for (int a = 0; a < num_motors; a++) begin
              if (microsteps[a] !== default_microsteps)
                report_value("microsteps", 64'(microsteps[a]), 64'(default_microsteps));
              if (current[a] !== default_current)
                report_value("current", 64'(current[a]), 64'(default_current));
            end
          end
          8'h1: send_word(words[i]);
          8'h2: begin
            send_word(words[i]);
            @(negedge CLK);
            if (word_send_data !== expects[i])
              report_value("word_send_data", word_send_data, expects[i]);
          end
          8'h5: begin
            mask = motor_mask_t'($urandom());
            send_word(words[i] | 64'(mask));
            @(negedge CLK);
            if (enable !== mask) report_value("enable", 64'(enable), 64'(mask));
          end
          8'h6: begin
            mask = motor_mask_t'($urandom());
            send_word(words[i] | 64'(mask));
            @(negedge CLK);
            if (brake !== mask) report_value("brake", 64'(brake), 64'(mask));
          end
          8'h7: begin
            @(negedge CLK);
            if (current !== expects[i][8*num_motors-1:0])
              report_value("current", 64'(current), expects[i]);
          end
          8'h8: begin
            @(negedge CLK);
            if (microsteps !== expects[i][8*num_motors-1:0])
              report_value("microsteps", 64'(microsteps), expects[i]);
          end
          8'h9: begin
            while (done_counts_q.size() == 0)
              @(negedge CLK);
            counts = done_counts_q.pop_front();
            done_cyc = done_cycle_q.pop_front();
            start_cyc = start_cycle_q.pop_front();
            if (counts !== expects[i]) report_value("step counts", counts, expects[i]);
            if (done_cyc - start_cyc < int'(words[i])) begin
              errors++;
              test_errors++;
              $display("Error at %0t ns: move ended %0d cycles after its header, minimum is %0d",
                       $time, done_cyc - start_cyc, int'(words[i]));
            end
          end
          8'ha: begin
            @(negedge CLK);
            if (dir !== expects[i][num_motors-1:0]) report_value("dir", 64'(dir), expects[i]);
          end
          8'hb: begin
            @(negedge CLK);
            if (buffer_dtr !== expects[i][0])
              report_value("buffer_dtr", 64'(buffer_dtr), 64'(expects[i][0]));
          end
          8'hc: begin
            while (buffer_dtr !== expects[i][0])
              @(negedge CLK);
          end
          8'he: begin
            @(negedge CLK);
            start_cycle_q.push_back(cycle); // Move timing starts at its header word
            send_word(words[i]);
          end
          default: begin
            errors++;
            test_errors++;
            $display("Error: unknown action %h on stimulus line %0d", actions[i], i);
          end
        endcase
      end
      finish_test(current_test);
    end

    $display("Tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

/* test/stepper_stim.txt */
# Columns: test id (decimal), action (hex), word (hex), expected value (hex)
# Actions: 0 reset state, 1 send, 2 send and check reply, 5/6 random enable/brake, 7 current,
# 8 microsteps, 9 move done (word = min cycles, expect = axis1|axis0 steps), a dir, b/c buffer_dtr
# e sends a move header word
1 0 0000000000000000 0000000000000000
2 5 0a00000000000000 0000000000000000
2 6 0b00000000000000 0000000000000000
2 2 fe00000000000000 0000000000010200
2 2 0000000000000000 0000000000000000
3 1 1001000000005a05 0000000000000000
3 7 0000000000000000 0000000000005a8c
3 8 0000000000000000 0000000000004540
4 1 2000000000000003 0000000000000000
4 e 0100000000000001 0000000000000000
4 1 0000000000000008 0000000000000000
4 1 4000000000000000 0000000000000000
4 1 0000000000000000 0000000000000000
4 1 2000000000000000 0000000000000000
4 1 2000000000000000 0000000000000000
4 a 0000000000000000 0000000000000001
4 b 0000000000000000 0000000000000001
4 9 0000000000000020 0000000300000004
5 1 200000000000000f 0000000000000000
5 e 0100000000000001 0000000000000000
5 1 0000000000000008 0000000000000000
5 1 4000000000000000 0000000000000000
5 1 0000000000000000 0000000000000000
5 1 2000000000000000 0000000000000000
5 1 2000000000000000 0000000000000000
5 e 0100000000000002 0000000000000000
5 1 0000000000000004 0000000000000000
5 1 8000000000000000 0000000000000000
5 1 0000000000000000 0000000000000000
5 1 0000000000000000 0000000000000000
5 1 0000000000000000 0000000000000000
5 b 0000000000000000 0000000000000000
5 9 0000000000000080 0000000300000004
5 a 0000000000000000 0000000000000002
5 9 0000000000000040 0000000000000004
5 c 0000000000000000 0000000000000001

/* verilog.f */
common/motion_cmd_pkg.sv
common/motion_cfg_pkg.sv
logic/command_fsm.sv
logic/clock_divider.sv
move_buffer/move_buffer.sv
dda/dda_fsm.sv
dda/dda_timer.sv
logic/stepper_core_top.sv
test/tb_stepper_core.sv

/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_stepper_core -f verilog.f -Mdir obj_dir -o sim_stepper

run: compile
	./obj_dir/sim_stepper | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
